// File: compile.f
+incdir+logic
logic/xain_pkg.sv
logic/settings_if.sv
logic/input_mapper.sv
logic/bridge_regs.sv
logic/pll_reconfig_seq.sv
logic/raster_counter.sv
logic/video_output_stage.sv
logic/xain_pocket_top.sv
tests/tb_xain_pocket_top.sv

// File: Makefile
# Verilator build, run, lint and clean for the housekeeping top level

VERILATOR ?= verilator
TOP       ?= tb_xain_pocket_top
RTL_TOP   ?= xain_pocket_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/tb_xain_pocket_top.sv
////////////////////
// testbench for the housekeeping top level
// register access, controller map, pll streaming
// raster timing and picture checks
////////////////////
`timescale 1ns/1ps
`include "xain_config.svh"

module tb_xain_pocket_top import xain_pkg::*; ();

  localparam int frame_cycles   = `XAIN_H_TOTAL * `XAIN_V_TOTAL;
  localparam int timeout_cycles = 3 * frame_cycles + 20000;  // raster test needs ~2 frames
  localparam int grp_seq    = 0;  // register, controller and pll tests
  localparam int grp_raster = 1;
  localparam int grp_pixel  = 2;

  logic         clk_74a;
  logic         reset_n;
  bridge_addr_t bridge_addr;
  logic         bridge_wr;
  bridge_data_t bridge_wr_data;
  bridge_data_t bridge_rd_data;
  key_map_t     cont1_key;
  key_map_t     cont2_key;
  player_byte_t player1;
  player_byte_t player2;
  switch_byte_t dip_sw0;
  switch_byte_t dip_sw1;
  logic         pll_locked;
  logic         cfg_waitrequest;
  logic         cfg_write;
  pll_addr_t    cfg_address;
  pll_data_t    cfg_data;
  logic         reconfig_pause;
  logic         core_reset;
  rgb_t         video_rgb;
  logic         video_de;
  logic         video_hs;
  logic         video_vs;

  integer seed;
  int     cycles = 0;
  int     checks = 0;
  int     group_errors [3] = '{0, 0, 0};
  int     vs_count = 0;
  int     last_vs = -1;
  int     last_hs = -1;
  int     hs_due = -1;
  int     de_run = 0;
  int     de_lines = 0;
  int     pixels = 0;
  int     blanked = 0;
  logic   pause_prev = 1'b0;

  xain_pocket_top i_xain_pocket_top (.*);

  initial begin
    clk_74a = 1'b0;
    forever #4 clk_74a = ~clk_74a;  // 125 mhz stand-in for 74.25
  end

  always @(posedge clk_74a) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("timeout after %0d cycles, a test never reached its end", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////
  // reference model
  ////////////////////

  // player2 in the high byte, as the inputs register reads
  function automatic logic [15:0] ref_players(input key_map_t c1, input key_map_t c2);
    ref_players = {c2[14], c1[14], c2[5], c2[4], c2[1], c2[0], c2[2], c2[3],
                   c2[15], c1[15], c1[5], c1[4], c1[1], c1[0], c1[2], c1[3]};
  endfunction

  function automatic rgb_t ref_pixel(input logic paused);
    ref_pixel = paused ? 24'd0 : {3{`XAIN_GREY}};
  endfunction

  function automatic pll_addr_t ref_pll_addr(input int idx);
    case (idx)
      0:       ref_pll_addr = 6'h00;
      1:       ref_pll_addr = 6'h04;  // m
      2:       ref_pll_addr = 6'h03;  // n
      7:       ref_pll_addr = 6'h08;
      8:       ref_pll_addr = 6'h02;  // kicks off the reload
      default: ref_pll_addr = 6'h05;  // c counters
    endcase
  endfunction

  function automatic pll_data_t ref_pll_data(input int idx, input logic hz60);
    case (idx)
      1:       ref_pll_data = hz60 ? 32'h0000_4F4F : 32'h0000_4040;
      2:       ref_pll_data = hz60 ? 32'h0002_0706 : 32'h0002_0605;
      3:       ref_pll_data = 32'h0002_0504;
      4:       ref_pll_data = 32'h0004_0909;
      5:       ref_pll_data = 32'h0008_4848;
      6:       ref_pll_data = 32'h000C_4848;
      7:       ref_pll_data = hz60 ? 32'h0000_0003 : 32'h0000_0002;
      default: ref_pll_data = 32'h0000_0000;
    endcase
  endfunction

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  ////////////////////
  // checks and bus access
  ////////////////////

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp,
                         input int grp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      group_errors[grp]++;
    end
  endtask

  task automatic check_true(input logic ok, input string what, input int grp);
    checks++;
    assert (ok) else begin
      $display("error at %0t: %s", $time, what);
      group_errors[grp]++;
    end
  endtask

  task automatic bus_write(input bridge_addr_t addr, input bridge_data_t data);
    @(negedge clk_74a);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(negedge clk_74a);
    bridge_wr      = 1'b0;
  endtask

  task automatic bus_read_check(input bridge_addr_t addr, input bridge_data_t exp,
                                input string name);
    @(negedge clk_74a);
    bridge_addr = addr;
    #2;  // read mux is combinational
    compare(name, bridge_rd_data, exp, grp_seq);
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic access_registers();
    logic [31:0] data;
    int          start;
    start = group_errors[grp_seq];
    compare("core_reset before lock", 32'(core_reset), 32'd1, grp_seq);
    pll_locked = 1'b1;
    @(negedge clk_74a);
    compare("core_reset after lock", 32'(core_reset), 32'd0, grp_seq);
    for (int i = 0; i < 8; i++) begin
      data = next_rand();
      bus_write(`XAIN_ADDR_DIP, data);
      compare("dip_sw0", 32'(dip_sw0), 32'(data[7:0]), grp_seq);
      compare("dip_sw1", 32'(dip_sw1), 32'(data[15:8]), grp_seq);
      bus_read_check(`XAIN_ADDR_DIP, {16'd0, data[15:0]}, "dip readback");
      data = next_rand();
      data[2] = 1'b0;  // stay at 57 hz for now
      bus_write(`XAIN_ADDR_MOD, data);
      bus_read_check(`XAIN_ADDR_MOD, {24'd0, data[7:0]}, "mod readback");
      data = next_rand();
      data[0] = 1'b1;  // every mapped address has a zero low byte
      bus_read_check(data, 32'd0, "unmapped read");
    end
    bus_write(`XAIN_ADDR_RESET, 32'd1);
    compare("core_reset switch set", 32'(core_reset), 32'd1, grp_seq);
    bus_read_check(`XAIN_ADDR_RESET, 32'd1, "reset readback");
    bus_write(`XAIN_ADDR_RESET, 32'd0);
    compare("core_reset switch clear", 32'(core_reset), 32'd0, grp_seq);
    $display("test register access: %0d errors", group_errors[grp_seq] - start);
  endtask

  task automatic map_controllers();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [15:0] exp_p;
    int          start;
    start = group_errors[grp_seq];
    for (int i = 0; i < 16; i++) begin
      r1 = next_rand();
      r2 = next_rand();
      exp_p = ref_players(r1[15:0], r2[15:0]);
      @(negedge clk_74a);
      cont1_key = r1[15:0];
      cont2_key = r2[15:0];
      @(negedge clk_74a);  // one register stage
      compare("player1", 32'(player1), 32'(exp_p[7:0]), grp_seq);
      compare("player2", 32'(player2), 32'(exp_p[15:8]), grp_seq);
      bus_read_check(`XAIN_ADDR_INPUTS, {16'd0, exp_p}, "inputs read");
    end
    $display("test controller mapping: %0d errors", group_errors[grp_seq] - start);
  endtask

  task automatic reconfigure(input logic hz60);
    logic [31:0] mod;
    int          writes;
    int          unstalled;
    int          relock;
    writes    = 0;
    unstalled = 0;
    relock    = 0;
    mod       = next_rand();
    mod[2]    = hz60;
    bus_write(`XAIN_ADDR_MOD, {24'd0, mod[7:0]});
    @(negedge clk_74a);
    compare("reconfig_pause rise", 32'(reconfig_pause), 32'd1, grp_seq);
    pll_locked = 1'b0;  // pll loses lock while reprogrammed
    while (reconfig_pause) begin
      if (cfg_write) begin
        // 255 wait edges, then one more loads the first entry
        if (writes == 0)
          compare("unstalled cycles to first write", unstalled, `XAIN_RECONFIG_WAIT + 1,
                  grp_seq);
        check_true(writes < `XAIN_PLL_PARAM_COUNT, "more than nine cfg_write cycles", grp_seq);
        compare("cfg_address", 32'(cfg_address), 32'(ref_pll_addr(writes)), grp_seq);
        compare("cfg_data", cfg_data, ref_pll_data(writes, hz60), grp_seq);
        writes++;
      end
      if (writes == `XAIN_PLL_PARAM_COUNT) relock++;
      pll_locked      = (relock > 16);
      cfg_waitrequest = ((next_rand() & 32'h3) == 32'h0);  // stall about a quarter
      if (!cfg_waitrequest && writes == 0) unstalled++;
      @(negedge clk_74a);
    end
    cfg_waitrequest = 1'b0;
    compare("cfg_write count", writes, `XAIN_PLL_PARAM_COUNT, grp_seq);
    compare("pll_locked at pause fall", 32'(pll_locked), 32'd1, grp_seq);
    repeat (8) begin
      @(negedge clk_74a);
      check_true(!cfg_write, "cfg_write after reconfig_pause fell", grp_seq);
    end
  endtask

  task automatic switch_refresh();
    int start;
    start = group_errors[grp_seq];
    while (!video_de) @(negedge clk_74a);  // start mid-picture so blanking shows
    reconfigure(1'b1);
    reconfigure(1'b0);
    $display("test pll reconfiguration: %0d errors", group_errors[grp_seq] - start);
  endtask

  ////////////////////
  // monitors
  ////////////////////

  always @(negedge clk_74a) begin
    if (reset_n) begin
      if (video_vs) begin
        if (last_vs >= 0) begin
          compare("video_vs period", cycles - last_vs, frame_cycles, grp_raster);
          compare("de lines per frame", de_lines, `XAIN_V_ACTIVE, grp_raster);
        end
        last_vs  = cycles;
        hs_due   = cycles + `XAIN_HS_OFFSET;
        de_lines = 0;
        vs_count++;
      end
      if (cycles == hs_due) compare("video_hs after vs", 32'(video_hs), 32'd1, grp_raster);
      if (video_hs) begin
        if (last_hs >= 0) compare("video_hs period", cycles - last_hs, `XAIN_H_TOTAL, grp_raster);
        last_hs = cycles;
      end
      if (video_de) begin
        de_run++;
      end else if (de_run != 0) begin  // end of a line's window
        compare("video_de run", de_run, `XAIN_H_ACTIVE, grp_raster);
        de_lines++;
        de_run = 0;
      end
    end
  end

  always @(negedge clk_74a) begin
    if (video_de) begin
      compare("video_rgb", 32'(video_rgb), 32'(ref_pixel(pause_prev)), grp_pixel);
      pixels++;
      if (pause_prev) blanked++;
    end
    pause_prev = reconfig_pause;  // colour register saw the level before the edge
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int total;
    seed            = 32'hd95c_1423;
    reset_n         = 1'b0;
    bridge_addr     = '0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    cont1_key       = '0;
    cont2_key       = '0;
    pll_locked      = 1'b0;
    cfg_waitrequest = 1'b0;
    repeat (2) @(posedge clk_74a);
    @(negedge clk_74a);
    reset_n = 1'b1;
    access_registers();
    map_controllers();
    switch_refresh();
    while (vs_count < 3) @(negedge clk_74a);
    @(negedge clk_74a);  // monitor finishes the last frame's checks
    $display("test raster timing: %0d frames, %0d errors", vs_count - 1,
             group_errors[grp_raster]);
    check_true(blanked > 0, "no blanked pixels seen during reconfiguration", grp_pixel);
    $display("test picture and blanking: %0d pixels, %0d blanked, %0d errors", pixels,
             blanked, group_errors[grp_pixel]);
    total = group_errors[grp_seq] + group_errors[grp_raster] + group_errors[grp_pixel];
    $display("summary: 5 tests, %0d checks, %0d errors", checks, total);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: logic/xain_pocket_top.sv
////////////////////
// housekeeping top level
// settings, inputs, pll sequencer, test raster
////////////////////
`timescale 1ns/1ps

module xain_pocket_top import xain_pkg::*; (
  input  logic         clk_74a,
  input  logic         reset_n,
  // host bridge
  input  bridge_addr_t bridge_addr,
  input  logic         bridge_wr,
  input  bridge_data_t bridge_wr_data,
  output bridge_data_t bridge_rd_data,
  // controllers
  input  key_map_t     cont1_key,
  input  key_map_t     cont2_key,
  output player_byte_t player1,
  output player_byte_t player2,
  output switch_byte_t dip_sw0,
  output switch_byte_t dip_sw1,
  // pll configuration port
  input  logic         pll_locked,
  input  logic         cfg_waitrequest,
  output logic         cfg_write,
  output pll_addr_t    cfg_address,
  output pll_data_t    cfg_data,
  output logic         reconfig_pause,
  output logic         core_reset,
  // video to scaler
  output rgb_t         video_rgb,
  output logic         video_de,
  output logic         video_hs,
  output logic         video_vs
);

  settings_if i_settings ();
  raster_if   i_raster ();

  // dips go straight to the game
  assign dip_sw0 = i_settings.dip_sw0;
  assign dip_sw1 = i_settings.dip_sw1;

  ////////////////////
  // settings path
  ////////////////////

  input_mapper i_input_mapper (
    .clk_74a   (clk_74a),
    .reset_n   (reset_n),
    .cont1_key (cont1_key),
    .cont2_key (cont2_key),
    .player1   (player1),
    .player2   (player2)
  );

  bridge_regs i_bridge_regs (
    .clk_74a        (clk_74a),
    .reset_n        (reset_n),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .player1        (player1),
    .player2        (player2),
    .bridge_rd_data (bridge_rd_data),
    .settings       (i_settings.regs)
  );

  pll_reconfig_seq i_pll_reconfig_seq (
    .clk_74a         (clk_74a),
    .reset_n         (reset_n),
    .settings        (i_settings.user),
    .pll_locked      (pll_locked),
    .cfg_waitrequest (cfg_waitrequest),
    .cfg_write       (cfg_write),
    .cfg_address     (cfg_address),
    .cfg_data        (cfg_data),
    .reconfig_pause  (reconfig_pause),
    .core_reset      (core_reset)
  );

  ////////////////////
  // video path
  ////////////////////

  raster_counter i_raster_counter (
    .clk_74a (clk_74a),
    .reset_n (reset_n),
    .raster  (i_raster.src)
  );

  video_output_stage i_video_output_stage (
    .clk_74a        (clk_74a),
    .reset_n        (reset_n),
    .raster         (i_raster.dst),
    .reconfig_pause (reconfig_pause),   // blanks while clocks move
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

endmodule

// File: logic/video_output_stage.sv
////////////////////
// registered syncs, data enable and colour
// picture blanks during pll reconfiguration
////////////////////
`timescale 1ns/1ps
`include "xain_config.svh"

module video_output_stage import xain_pkg::*; (
  input  logic   clk_74a,
  input  logic   reset_n,
  raster_if.dst  raster,
  input  logic   reconfig_pause,
  output rgb_t   video_rgb,
  output logic   video_de,
  output logic   video_hs,
  output logic   video_vs
);

  logic line_active;  // current line inside the vertical window
  logic de_next;

  // line_active settles at x = 1, long before the window opens
  assign de_next = line_active &&
                   (raster.x >= `XAIN_H_BPORCH) &&
                   (raster.x <  `XAIN_H_BPORCH + `XAIN_H_ACTIVE);

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      video_vs    <= 1'b0;
      video_hs    <= 1'b0;
      video_de    <= 1'b0;
      line_active <= 1'b0;
    end else begin
      video_vs <= raster.frame_start;                 // one clock per frame
      video_hs <= (raster.x == `XAIN_HS_OFFSET);      // trails vs, never together
      video_de <= de_next;
      if (raster.line_start) begin                    // vertical test once a line
        line_active <= (raster.y >= `XAIN_V_BPORCH) &&
                       (raster.y <  `XAIN_V_BPORCH + `XAIN_V_ACTIVE);
      end
    end
  end

  // flat grey, black outside the window or while paused
  always_ff @(posedge clk_74a) begin
    video_rgb <= (de_next && !reconfig_pause) ? {3{`XAIN_GREY}} : '0;
  end

endmodule

// File: logic/raster_counter.sv
////////////////////
// raster position bundle
// horizontal and vertical counters
////////////////////
`timescale 1ns/1ps
`include "xain_config.svh"

interface raster_if import xain_pkg::*; ();

  raster_pos_t x;
  raster_pos_t y;
  logic        frame_start;  // x and y both zero
  logic        line_start;   // x zero

  modport src (output x, y, frame_start, line_start);
  modport dst (input  x, y, frame_start, line_start);

endinterface

module raster_counter import xain_pkg::*; (
  input  logic   clk_74a,
  input  logic   reset_n,
  raster_if.src  raster
);

  // free running, never stalls
  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      raster.x <= '0;
      raster.y <= '0;
    end else if (raster.x == `XAIN_H_TOTAL - 1) begin
      raster.x <= '0;                       // end of line
      if (raster.y == `XAIN_V_TOTAL - 1) raster.y <= '0;
      else raster.y <= raster.y + 1'b1;
    end else begin
      raster.x <= raster.x + 1'b1;
    end
  end

  // marks line up with the position they describe
  assign raster.line_start  = (raster.x == '0);
  assign raster.frame_start = raster.line_start && (raster.y == '0);

endmodule

// File: logic/pll_reconfig_seq.sv
////////////////////
// refresh-mode change detect and pause timer
// pll table streaming over the config port
// core reset from switch and first lock
////////////////////
`timescale 1ns/1ps
`include "xain_config.svh"

module pll_reconfig_seq import xain_pkg::*; (
  input  logic      clk_74a,
  input  logic      reset_n,
  settings_if.user  settings,
  input  logic      pll_locked,
  input  logic      cfg_waitrequest,
  output logic      cfg_write,
  output pll_addr_t cfg_address,
  output pll_data_t cfg_data,
  output logic      reconfig_pause,
  output logic      core_reset
);

  // register order is the same for both modes
  localparam pll_addr_t tbl_addr [`XAIN_PLL_PARAM_COUNT] = '{
    6'h00,                             // waitrequest mode
    6'h04, 6'h03,                      // m, n counters
    6'h05, 6'h05, 6'h05, 6'h05,        // c counters
    6'h08,                             // bandwidth
    6'h02                              // start reconfigure
  };
  localparam pll_data_t tbl_57hz [`XAIN_PLL_PARAM_COUNT] = '{
    32'h0000_0000, 32'h0000_4040, 32'h0002_0605,
    32'h0002_0504, 32'h0004_0909, 32'h0008_4848,
    32'h000C_4848, 32'h0000_0002, 32'h0000_0000
  };
  localparam pll_data_t tbl_60hz [`XAIN_PLL_PARAM_COUNT] = '{
    32'h0000_0000, 32'h0000_4F4F, 32'h0002_0706,  // m and n differ
    32'h0002_0504, 32'h0004_0909, 32'h0008_4848,
    32'h000C_4848, 32'h0000_0003, 32'h0000_0000
  };

  reconfig_state_t state;
  video_timing_t   timing_lat;   // mode the pll was last set for
  video_timing_t   timing_req;
  param_idx_t      param_idx;
  logic [7:0]      wait_cnt;
  logic            seen_locked;  // pll locked at least once
  logic            unstalled;

  assign timing_req = video_timing_t'(settings.mod_sw[2]);
  assign unstalled  = ~cfg_waitrequest;   // port busy freezes everything
  assign core_reset = settings.reset_sw | ~seen_locked;

  ////////////////////
  // sequencer
  ////////////////////

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      state          <= RC_IDLE;
      timing_lat     <= VIDEO_57HZ;
      param_idx      <= '0;
      wait_cnt       <= '0;
      reconfig_pause <= 1'b0;
      cfg_write      <= 1'b0;
      seen_locked    <= 1'b0;
    end else begin
      cfg_write <= 1'b0;                  // single-cycle strobe
      if (pll_locked) seen_locked <= 1'b1;
      if (unstalled) begin
        case (state)
          RC_IDLE: begin
            if (pll_locked && timing_req != timing_lat) begin
              timing_lat     <= timing_req;
              reconfig_pause <= 1'b1;     // hold the picture
              wait_cnt       <= '0;
              state          <= RC_WAIT;
            end
          end
          RC_WAIT: begin
            wait_cnt <= wait_cnt + 8'd1;
            if (wait_cnt == 8'(`XAIN_RECONFIG_WAIT - 1)) begin
              param_idx <= '0;
              state     <= RC_STREAM;
            end
          end
          RC_STREAM: begin
            cfg_write <= 1'b1;
            param_idx <= param_idx + 5'd1;
            if (param_idx == 5'(`XAIN_PLL_PARAM_COUNT - 1)) state <= RC_RELOCK;
          end
          RC_RELOCK: begin
            if (pll_locked) begin         // new clocks are stable
              reconfig_pause <= 1'b0;
              state          <= RC_IDLE;
            end
          end
          default: state <= RC_IDLE;
        endcase
      end
    end
  end

  // entry payload, loaded alongside the write strobe
  always_ff @(posedge clk_74a) begin
    if (state == RC_STREAM && unstalled) begin
      cfg_address <= tbl_addr[param_idx[3:0]];
      cfg_data    <= (timing_lat == VIDEO_60HZ) ? tbl_60hz[param_idx[3:0]]
                                                : tbl_57hz[param_idx[3:0]];
    end
  end

endmodule

// File: logic/bridge_regs.sv
////////////////////
// host bridge settings registers
// reset switch, dip bytes, modifier byte
// combinational read-data decode
////////////////////
`timescale 1ns/1ps
`include "xain_config.svh"

module bridge_regs import xain_pkg::*; (
  input  logic         clk_74a,
  input  logic         reset_n,
  input  bridge_addr_t bridge_addr,
  input  logic         bridge_wr,
  input  bridge_data_t bridge_wr_data,
  input  player_byte_t player1,
  input  player_byte_t player2,
  output bridge_data_t bridge_rd_data,
  settings_if.regs     settings
);

  ////////////////////
  // writes
  ////////////////////

  // exact address match, the host only pokes the base
  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      settings.reset_sw <= 1'b0;
      settings.dip_sw0  <= '0;
      settings.dip_sw1  <= '0;
      settings.mod_sw   <= '0;   // 57 hz
    end else if (bridge_wr) begin
      case (bridge_addr)
        `XAIN_ADDR_RESET: begin
          settings.reset_sw <= bridge_wr_data[0];
        end
        `XAIN_ADDR_DIP: begin
          settings.dip_sw0 <= bridge_wr_data[7:0];
          settings.dip_sw1 <= bridge_wr_data[15:8];
        end
        `XAIN_ADDR_MOD: begin
          settings.mod_sw <= bridge_wr_data[7:0];
        end
        default: begin
          // inputs address and holes ignore writes
        end
      endcase
    end
  end

  ////////////////////
  // reads
  ////////////////////

  always_comb begin
    case (bridge_addr)
      `XAIN_ADDR_RESET:  bridge_rd_data = {31'd0, settings.reset_sw};
      `XAIN_ADDR_DIP:    bridge_rd_data = {16'd0, settings.dip_sw1, settings.dip_sw0};
      `XAIN_ADDR_MOD:    bridge_rd_data = {24'd0, settings.mod_sw};
      `XAIN_ADDR_INPUTS: bridge_rd_data = {16'd0, player2, player1};  // live pad state
      default:           bridge_rd_data = '0;                         // unmapped
    endcase
  end

endmodule

// File: logic/input_mapper.sv
////////////////////
// controller keys to player bytes
////////////////////
`timescale 1ns/1ps

module input_mapper import xain_pkg::*; (
  input  logic         clk_74a,
  input  logic         reset_n,
  input  key_map_t     cont1_key,
  input  key_map_t     cont2_key,
  output player_byte_t player1,
  output player_byte_t player2
);

  // game order, msb first
  // player1: start2 start1 sw2 sw1 down up left right
  // player2: coin2 coin1 sw2 sw1 down up left right
  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      player1 <= '1;  // nothing pressed
      player2 <= '1;
    end else begin
      player1 <= {cont2_key[15], cont1_key[15],             // starts
                  cont1_key[5],  cont1_key[4],              // buttons
                  cont1_key[1],  cont1_key[0],              // down, up
                  cont1_key[2],  cont1_key[3]};             // left, right
      player2 <= {cont2_key[14], cont1_key[14],             // coins on select
                  cont2_key[5],  cont2_key[4],
                  cont2_key[1],  cont2_key[0],
                  cont2_key[2],  cont2_key[3]};
    end
  end

endmodule

// File: logic/settings_if.sv
////////////////////
// settings bundle from the register file
////////////////////
`timescale 1ns/1ps

interface settings_if import xain_pkg::*; ();

  logic         reset_sw;  // core reset request
  switch_byte_t dip_sw0;
  switch_byte_t dip_sw1;
  switch_byte_t mod_sw;    // bit 2 selects 60 hz

  // register file side
  modport regs (output reset_sw, dip_sw0, dip_sw1, mod_sw);

  // consumers, all plain levels
  modport user (input reset_sw, dip_sw0, dip_sw1, mod_sw);

endinterface

// File: logic/xain_pkg.sv
////////////////////
// shared vector types and fsm encodings
////////////////////
package xain_pkg;

  // host bridge
  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  // settings and inputs
  typedef logic [7:0]  switch_byte_t;   // dip or modifier byte
  typedef logic [15:0] key_map_t;       // pocket controller bitmap
  typedef logic [7:0]  player_byte_t;   // active low, game order

  // pll configuration port
  typedef logic [5:0]  pll_addr_t;
  typedef logic [31:0] pll_data_t;
  typedef logic [4:0]  param_idx_t;     // table entry

  // video
  typedef logic [9:0]  raster_pos_t;
  typedef logic [23:0] rgb_t;           // r in 23:16, b in 7:0

  // refresh mode, follows modifier bit 2
  typedef enum logic {
    VIDEO_57HZ = 1'b0,
    VIDEO_60HZ = 1'b1
  } video_timing_t;

  typedef enum logic [1:0] {
    RC_IDLE   = 2'd0,  // watching for a mode change
    RC_WAIT   = 2'd1,  // pause before streaming
    RC_STREAM = 2'd2,  // table writes
    RC_RELOCK = 2'd3   // waiting on pll lock
  } reconfig_state_t;

endpackage

// File: logic/xain_config.svh
////////////////////
// bridge register map and pll table size
// reconfiguration pause length
// raster geometry and test picture level
////////////////////
`ifndef XAIN_CONFIG_SVH
`define XAIN_CONFIG_SVH

// bridge register addresses
`define XAIN_ADDR_RESET      32'hF000_0000  // reset switch, bit 0
`define XAIN_ADDR_DIP        32'hF100_0000  // dip bytes 0 and 1
`define XAIN_ADDR_MOD        32'hF200_0000  // modifier byte
`define XAIN_ADDR_INPUTS     32'hFC00_0000  // player bytes, read only

// pll reconfiguration
`define XAIN_PLL_PARAM_COUNT 9    // address/data pairs per table
`define XAIN_RECONFIG_WAIT   255  // settle clocks before streaming

// raster, 400 x 512 = 204800 clocks per frame
`define XAIN_H_TOTAL         400
`define XAIN_H_ACTIVE        320
`define XAIN_H_BPORCH        10
`define XAIN_V_TOTAL         512
`define XAIN_V_ACTIVE        240
`define XAIN_V_BPORCH        10
`define XAIN_HS_OFFSET       3      // hs a few clocks after vs
`define XAIN_GREY            8'd60  // per channel

`endif
